//--- cnn_pkg.sv
package cnn_pkg;

  localparam int UNITS           = 4;
  localparam int WORD_WIDTH_ACC  = 16;
  localparam int MEMBERS         = 6;
  localparam int B_SLOTS         = MEMBERS / 3;  // Mux slots in stage B.
  localparam int KW_MAX          = 3;
  localparam int SW_MAX          = 2;
  localparam int CLR_WIDTH       = 2;
  localparam int BITS_MEMBERS    = 3;
  localparam int BITS_OUT_SHIFT  = 1;
  localparam int USER_BASE_WIDTH = 6;
  localparam int LRELU_SHIFT     = 3;
  localparam int OUT_WIDTH       = 8;
  localparam int OUT_MAX         = 2**(OUT_WIDTH-1) - 1;
  localparam int OUT_MIN         = -(2**(OUT_WIDTH-1));

  typedef logic signed [WORD_WIDTH_ACC-1:0] acc_word_t;
  typedef logic signed [OUT_WIDTH-1:0]      out_word_t;
  typedef logic [CLR_WIDTH-1:0]             clr_t;
  typedef logic [BITS_MEMBERS-1:0]          shift_a_t;
  typedef logic [BITS_OUT_SHIFT-1:0]        shift_b_t;

  typedef acc_word_t [UNITS-1:0]   member_t;
  typedef member_t   [MEMBERS-1:0] bank_t;
  typedef out_word_t [UNITS-1:0]   out_beat_t;

  typedef struct packed {
    logic                       kw2;   // 0 selects k=1, 1 selects k=3.
    logic                       sw_1;  // Stride minus one.
    logic [USER_BASE_WIDTH-3:0] tag;
  } user_base_t;

  typedef struct packed {
    clr_t [MEMBERS-1:0] clr;
    shift_b_t           shift_b;
    shift_a_t           shift_a;
    user_base_t         base;
  } dw_user_in_t;

  typedef struct packed {
    clr_t       clr;
    user_base_t base;
  } dw_user_out_t;

  // Entry of the shift registers in both bank stages.
  typedef struct packed {
    member_t data;
    clr_t    clr;
  } bank_entry_t;

endpackage

//--- axis_skid.sv
`timescale 1ns/1ps

module axis_skid
  import cnn_pkg::*;
#(
  parameter int DATA_WIDTH = 64
) (
  input  logic                  aclk,
  input  logic                  rst,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  logic [DATA_WIDTH-1:0] s_data,
  input  dw_user_out_t          s_user,
  input  logic                  s_last,
  output logic                  m_valid,
  input  logic                  m_ready,
  output logic [DATA_WIDTH-1:0] m_data,
  output dw_user_out_t          m_user,
  output logic                  m_last
);

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    dw_user_out_t          user;
    logic                  last;
  } beat_t;

  beat_t in_beat;
  beat_t main_q;
  beat_t skid_q;
  logic  skid_valid;
  logic  load_main;

  assign in_beat.data = s_data;
  assign in_beat.user = s_user;
  assign in_beat.last = s_last;

  assign load_main = ~m_valid | m_ready;  // The output register is free this cycle.
  assign s_ready   = ~skid_valid;

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_main) begin
      m_valid    <= skid_valid | s_valid;
      skid_valid <= 1'b0;
    end else if (s_valid && !skid_valid) begin
      skid_valid <= 1'b1;  // Output is stalled, so the incoming beat parks here.
    end
  end

  always_ff @(posedge aclk) begin
    if (load_main) begin
      main_q <= skid_valid ? skid_q : in_beat;
    end else if (!skid_valid) begin
      skid_q <= in_beat;
    end
  end

  assign m_data = main_q.data;
  assign m_user = main_q.user;
  assign m_last = main_q.last;

endmodule

//--- axis_dw_bank.sv
`timescale 1ns/1ps

module axis_dw_bank
  import cnn_pkg::*;
(
  input  logic         aclk,
  input  logic         rst,
  input  logic         s_valid,
  output logic         s_ready,
  input  bank_t        s_data,
  input  dw_user_in_t  s_user,
  input  logic         s_last,
  output logic         m_valid,
  input  logic         m_ready,
  output member_t      m_data,
  output dw_user_out_t m_user,
  output logic         m_last
);

  logic b_ready;
  logic slice_ready;

  shift_a_t                  count_a;
  logic                      count_a_last;
  logic                      count_a_en;
  bank_entry_t [MEMBERS-1:0] reg_a;
  bank_entry_t [MEMBERS-1:0] reg_a_in;
  logic                      a_valid;
  logic                      a_last_q;
  logic                      a_last;
  shift_b_t                  a_shift_b;
  user_base_t                a_base;

  shift_b_t                                         count_b;
  logic                                             count_b_last;
  logic                                             count_b_en;
  bank_entry_t [KW_MAX/2:0][SW_MAX-1:0][B_SLOTS-1:0] b_mux;
  bank_entry_t [B_SLOTS-1:0]                        reg_b;
  bank_entry_t [B_SLOTS-1:0]                        reg_b_in;
  logic                                             b_valid;
  logic                                             b_last_q;
  logic                                             b_last;
  user_base_t                                       b_base;
  dw_user_out_t                                     b_user;

  // Stage A steps whenever stage B takes its current bank.
  assign count_a_last = (count_a == '0);
  assign count_a_en   = b_ready & (~count_a_last | s_valid);
  assign s_ready      = b_ready & count_a_last;

  always_comb begin
    if (count_a_last) begin
      for (int m = 0; m < MEMBERS; m++) begin
        reg_a_in[m].data = s_data[m];
        reg_a_in[m].clr  = s_user.clr[m];
      end
    end else begin
      reg_a_in = {reg_a[MEMBERS-2:0], bank_entry_t'('0)};  // Shift up one member.
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      count_a <= '0;
      a_valid <= 1'b0;
    end else begin
      if (count_a_en) count_a <= count_a_last ? s_user.shift_a : count_a - 1'b1;
      if (s_ready) a_valid <= s_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (count_a_en) reg_a <= reg_a_in;
    if (s_valid && s_ready) begin
      a_last_q  <= s_last;
      a_shift_b <= s_user.shift_b;
      a_base    <= s_user.base;
    end
  end

  assign a_last = a_last_q & count_a_last;

  assign count_b_last = (count_b == '0);
  assign count_b_en   = slice_ready & (~count_b_last | a_valid);
  assign b_ready      = slice_ready & count_b_last;

  // Kernel geometry mux. With j = k + sw_1, every member at m mod j == j-1 lands in slot m/j.
  always_comb begin
    b_mux          = '0;
    b_mux[0][0][0] = reg_a[MEMBERS-1];
    for (int kw2 = 1; kw2 <= KW_MAX/2; kw2++) begin
      for (int sw_1 = 0; sw_1 < SW_MAX; sw_1++) begin
        for (int m = 0; m < MEMBERS; m++) begin
          if (m % (2*kw2 + 1 + sw_1) == 2*kw2 + sw_1) begin
            b_mux[kw2][sw_1][m / (2*kw2 + 1 + sw_1)] = reg_a[m];
          end
        end
      end
    end
  end

  assign reg_b_in = count_b_last ? b_mux[a_base.kw2][a_base.sw_1]
                                 : {bank_entry_t'('0), reg_b[B_SLOTS-1:1]};

  always_ff @(posedge aclk) begin
    if (rst) begin
      count_b <= '0;
      b_valid <= 1'b0;
    end else begin
      if (count_b_en) count_b <= count_b_last ? a_shift_b : count_b - 1'b1;
      if (b_ready) b_valid <= a_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (count_b_en) reg_b <= reg_b_in;
    if (a_valid && b_ready) begin
      b_last_q <= a_last;
      b_base   <= a_base;
    end
  end

  assign b_last      = b_last_q & count_b_last;  // Only the final slot of the final A step.
  assign b_user.clr  = reg_b[0].clr;
  assign b_user.base = b_base;

  axis_skid #(
    .DATA_WIDTH ($bits(member_t))
  ) u_slice (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (b_valid),
    .s_ready (slice_ready),
    .s_data  (reg_b[0].data),
    .s_user  (b_user),
    .s_last  (b_last),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_user  (m_user),
    .m_last  (m_last)
  );

endmodule

//--- lrelu_engine.sv
`timescale 1ns/1ps

module lrelu_engine
  import cnn_pkg::*;
(
  input  logic         aclk,
  input  logic         rst,
  input  logic         s_valid,
  output logic         s_ready,
  input  member_t      s_data,
  input  dw_user_out_t s_user,
  input  logic         s_last,
  output logic         m_valid,
  input  logic         m_ready,
  output out_beat_t    m_data,
  output dw_user_out_t m_user,
  output logic         m_last
);

  out_beat_t relu_data;

  // Negative inputs are scaled down by an arithmetic shift before clipping to int8.
  function automatic out_word_t lrelu_sat(input acc_word_t x);
    acc_word_t y;
    y = x[WORD_WIDTH_ACC-1] ? acc_word_t'(x >>> LRELU_SHIFT) : x;
    if (y > OUT_MAX) return out_word_t'(OUT_MAX);
    if (y < OUT_MIN) return out_word_t'(OUT_MIN);
    return out_word_t'(y);
  endfunction

  always_comb begin
    for (int u = 0; u < UNITS; u++) begin
      relu_data[u] = lrelu_sat(s_data[u]);
    end
  end

  axis_skid #(
    .DATA_WIDTH ($bits(out_beat_t))
  ) u_slice (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (relu_data),
    .s_user  (s_user),
    .s_last  (s_last),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_user  (m_user),
    .m_last  (m_last)
  );

endmodule

//--- acc_out_top.sv
`timescale 1ns/1ps

module acc_out_top
  import cnn_pkg::*;
(
  input  logic         aclk,
  input  logic         rst,
  input  logic         s_valid,
  output logic         s_ready,
  input  bank_t        s_data,
  input  dw_user_in_t  s_user,
  input  logic         s_last,
  output logic         m_valid,
  input  logic         m_ready,
  output out_beat_t    m_data,
  output dw_user_out_t m_user,
  output logic         m_last
);

  logic         mid_valid;
  logic         mid_ready;
  member_t      mid_data;
  dw_user_out_t mid_user;
  logic         mid_last;

  axis_dw_bank u_bank (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .s_user  (s_user),
    .s_last  (s_last),
    .m_valid (mid_valid),
    .m_ready (mid_ready),
    .m_data  (mid_data),
    .m_user  (mid_user),
    .m_last  (mid_last)
  );

  lrelu_engine u_lrelu (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (mid_valid),
    .s_ready (mid_ready),
    .s_data  (mid_data),
    .s_user  (mid_user),
    .s_last  (mid_last),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_user  (m_user),
    .m_last  (m_last)
  );

endmodule

//--- tb_acc_out_asserts.sv
`timescale 1ns/1ps

module tb_acc_out_asserts
  import cnn_pkg::*;
(
  input logic         aclk,
  input logic         rst,
  input logic         mid_valid,
  input logic         mid_ready,
  input member_t      mid_data,
  input dw_user_out_t mid_user,
  input logic         mid_last,
  input logic         m_valid,
  input logic         m_ready,
  input out_beat_t    m_data,
  input dw_user_out_t m_user,
  input logic         m_last
);

  // A stalled beat keeps valid and payload until its transfer.
  mid_valid_hold: assert property (@(posedge aclk) disable iff (rst)
    mid_valid && !mid_ready |=> mid_valid)
    else $error("mid_valid dropped before its transfer");

  m_valid_hold: assert property (@(posedge aclk) disable iff (rst)
    m_valid && !m_ready |=> m_valid)
    else $error("m_valid dropped before its transfer");

  mid_payload_stable: assert property (@(posedge aclk) disable iff (rst)
    mid_valid && !mid_ready |=> $stable({mid_data, mid_user, mid_last}))
    else $error("mid payload changed while stalled");

  m_payload_stable: assert property (@(posedge aclk) disable iff (rst)
    m_valid && !m_ready |=> $stable({m_data, m_user, m_last}))
    else $error("m payload changed while stalled");

  reset_quiet: assert property (@(posedge aclk) rst |=> !mid_valid && !m_valid)
    else $error("a valid was high during reset");

endmodule

//--- tb_acc_out.sv
`timescale 1ns/1ps

module tb_acc_out
  import cnn_pkg::*;
();

  localparam int NUM_BEATS    = 300;
  localparam int UNIT_BEATS   = 16;  // Leading beats with both shifts at zero.
  localparam int MAX_CYCLES   = 50000;
  localparam int DRAIN_CYCLES = 8;

  typedef struct packed {
    out_beat_t    data;
    dw_user_out_t user;
    logic         last;
  } expect_t;

  logic         aclk;
  logic         rst;
  logic         s_valid;
  logic         s_ready;
  bank_t        s_data;
  dw_user_in_t  s_user;
  logic         s_last;
  logic         m_valid;
  logic         m_ready;
  out_beat_t    m_data;
  dw_user_out_t m_user;
  logic         m_last;

  expect_t     expected[$];
  int          errors;
  int          issued;
  int          accepted;
  int          produced;
  int          cycle;
  logic        in_fire;
  logic        out_fire;

  acc_out_top u_dut (.*);

  bind acc_out_top tb_acc_out_asserts u_asserts (.*);

  always #2 aclk = ~aclk;

  // Half of the words sit in a narrow band where the slope and both clip limits meet.
  function automatic acc_word_t rand_word();
    if ($urandom_range(1) == 0) return acc_word_t'($urandom());
    return acc_word_t'(int'($urandom_range(1300)) - 1100);
  endfunction

  function automatic out_word_t relu_ref(input acc_word_t x);
    int v;
    v = int'(x);
    if (v < 0) v = -((7 - v) / 8);  // Floor of v/8.
    if (v > 127) v = 127;
    if (v < -128) v = -128;
    return out_word_t'(v);
  endfunction

  task automatic make_beat();
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) s_data[m][u] = rand_word();
      s_user.clr[m] = clr_t'($urandom_range(3));
    end
    s_user.shift_a   = (issued < UNIT_BEATS) ? '0 : shift_a_t'($urandom_range(MEMBERS - 1));
    s_user.shift_b   = (issued < UNIT_BEATS) ? '0 : shift_b_t'($urandom_range(B_SLOTS - 1));
    s_user.base.kw2  = 1'($urandom_range(1));
    s_user.base.sw_1 = s_user.base.kw2 ? 1'($urandom_range(1)) : 1'b0;  // Stride two needs k=3.
    s_user.base.tag  = 4'($urandom_range(15));
    s_last           = 1'($urandom_range(1));
  endtask

  // Expands one accepted input beat into its output beats, A steps outer and B steps inner.
  task automatic expand_beat(input bank_t bank, input dw_user_in_t user, input logic last);
    member_t sh [MEMBERS];
    clr_t    sc [MEMBERS];
    member_t sd [B_SLOTS];
    clr_t    sclr [B_SLOTS];
    expect_t e;
    int      j;
    for (int i = 0; i <= int'(user.shift_a); i++) begin
      for (int m = 0; m < MEMBERS; m++) begin
        sh[m] = (m >= i) ? bank[m - i] : '0;
        sc[m] = (m >= i) ? user.clr[m - i] : '0;
      end
      for (int t = 0; t < B_SLOTS; t++) begin
        sd[t]   = '0;
        sclr[t] = '0;
      end
      if (!user.base.kw2) begin
        sd[0]   = sh[MEMBERS - 1];
        sclr[0] = sc[MEMBERS - 1];
      end else begin
        j = 3 + int'(user.base.sw_1);
        for (int m = 0; m < MEMBERS; m++) begin
          if (m % j == j - 1) begin
            sd[m / j]   = sh[m];
            sclr[m / j] = sc[m];
          end
        end
      end
      for (int t = 0; t <= int'(user.shift_b); t++) begin
        for (int u = 0; u < UNITS; u++) e.data[u] = relu_ref(sd[t][u]);
        e.user.clr  = sclr[t];
        e.user.base = user.base;
        e.last      = last && (i == int'(user.shift_a)) && (t == int'(user.shift_b));
        expected.push_back(e);
      end
    end
  endtask

  task automatic check_output();
    expect_t e;
    if (expected.size() == 0) begin
      $display("Output beat %0d arrived while the model expected nothing.", produced);
      errors++;
    end else begin
      e = expected.pop_front();
      if (m_data !== e.data) begin
        $display("ERROR beat %0d m_data expected %h actual %h", produced, e.data, m_data);
        errors++;
      end
      if (m_user !== e.user) begin
        $display("ERROR beat %0d m_user expected %h actual %h", produced, e.user, m_user);
        errors++;
      end
      if (m_last !== e.last) begin
        $display("ERROR beat %0d m_last expected %h actual %h", produced, e.last, m_last);
        errors++;
      end
    end
    produced++;
  endtask

  initial begin
    void'($urandom(9689));
    aclk     = 1'b0;
    rst      = 1'b1;
    s_valid  = 1'b0;
    s_data   = '0;
    s_user   = '0;
    s_last   = 1'b0;
    m_ready  = 1'b0;
    in_fire  = 1'b0;
    out_fire = 1'b0;
    errors   = 0;
    issued   = 0;
    accepted = 0;
    produced = 0;
    cycle    = 0;

    for (int c = 0; c < 4; c++) begin
      @(negedge aclk);
      if (m_valid !== 1'b0) begin
        $display("m_valid was high while reset was asserted.");
        errors++;
      end
    end
    rst = 1'b0;

    // Inputs change on the falling edge and are sampled 1 ns later, well before the rising edge.
    while ((accepted < NUM_BEATS || expected.size() != 0) && cycle < MAX_CYCLES) begin
      @(negedge aclk);
      if (cycle == 0 && m_valid !== 1'b0) begin
        $display("m_valid was high on the first cycle after reset.");
        errors++;
      end
      if (in_fire) s_valid = 1'b0;
      if (!s_valid && issued < NUM_BEATS && $urandom_range(3) != 0) begin
        make_beat();
        s_valid = 1'b1;
        issued++;
      end
      m_ready = ($urandom_range(3) != 0);
      #1;
      in_fire  = s_valid & s_ready;
      out_fire = m_valid & m_ready;
      if (out_fire) check_output();
      if (in_fire) begin
        expand_beat(s_data, s_user, s_last);
        accepted++;
      end
      cycle++;
    end

    if (accepted < NUM_BEATS || expected.size() != 0) begin
      $display("Timed out with %0d of %0d inputs accepted and %0d outputs still expected.",
               accepted, NUM_BEATS, expected.size());
      errors++;
    end else begin
      for (int c = 0; c < DRAIN_CYCLES; c++) begin
        @(negedge aclk);
        m_ready = 1'b1;
        #1;
        if (m_valid !== 1'b0) begin
          $display("An extra output beat appeared after the model queue was empty.");
          errors++;
        end
      end
    end

    $display("Run done: %0d inputs, %0d outputs checked, %0d errors.", accepted, produced, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
cnn_pkg.sv
axis_skid.sv
axis_dw_bank.sv
lrelu_engine.sv
acc_out_top.sv
tb_acc_out_asserts.sv
tb_acc_out.sv

//--- Makefile
TOP = tb_acc_out

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q "STATUS: FAIL" sim.log

obj_dir/V$(TOP): all.f $(wildcard *.sv)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f all.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log
